// ==== src/bpf_pkg.sv ====
`default_nettype none

package bpf_pkg;

	// memory sizes
	localparam int CODE_ADDR_W = 10;                // 1024 instructions
	localparam int INSN_W      = 64;                // opcode, jt, jf, k
	localparam int PKT_ADDR_W  = 8;                 // byte address into packet buffer
	localparam int PKT_DEPTH   = 2**PKT_ADDR_W;     // 256 byte frame store

	// instruction word layout, msb first
	localparam int OPC_W  = 16;
	localparam int OFF_W  = 8;                      // jt / jf width
	localparam int K_W    = 32;
	localparam int OPC_LSB = 48;
	localparam int JT_LSB  = 40;
	localparam int JF_LSB  = 32;

	// instruction class, opcode bits 2:0
	localparam logic [2:0] CLS_LD  = 3'h0;
	localparam logic [2:0] CLS_LDX = 3'h1;
	localparam logic [2:0] CLS_JMP = 3'h5;
	localparam logic [2:0] CLS_RET = 3'h6;

	// load size, opcode bits 4:3
	localparam logic [1:0] SIZE_H = 2'h1;           // halfword, big endian
	localparam logic [1:0] SIZE_B = 2'h2;

	// load mode, opcode bits 7:5
	localparam logic [2:0] MODE_ABS = 3'h1;         // [k]
	localparam logic [2:0] MODE_IND = 3'h2;         // [x + k]
	localparam logic [2:0] MODE_MSH = 3'h5;         // x = 4 * ([k] & 0xf)

	// jump operation, opcode bits 7:4
	localparam logic [3:0] JOP_JEQ  = 4'h1;
	localparam logic [3:0] JOP_JSET = 4'h4;

	// operand source, opcode bit 3
	localparam logic SRC_K = 1'b0;                  // immediate
	localparam logic SRC_A = 1'b1;                  // accumulator, ret only here

	// filter core states
	localparam int ST_W = 3;
	localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
	localparam logic [ST_W-1:0] ST_FETCH = 3'd1;
	localparam logic [ST_W-1:0] ST_WAIT  = 3'd2;
	localparam logic [ST_W-1:0] ST_EXEC  = 3'd3;
	localparam logic [ST_W-1:0] ST_LOAD  = 3'd4;

	// the 16 bit opcode seen as a load or as a jump/return
	typedef union packed {
		struct packed {
			logic [7:0] rsvd;
			logic [2:0] mode;
			logic [1:0] size;
			logic [2:0] cls;
		} ld;
		struct packed {
			logic [7:0] rsvd;
			logic [3:0] op;
			logic       src;
			logic [2:0] cls;
		} jmp;
	} bpf_opcode_t;

endpackage

`default_nettype wire

// ==== src/code_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module code_ram
	import bpf_pkg::*;
(
	input  wire                    clk,
	input  wire                    wr_en,
	input  wire  [CODE_ADDR_W-1:0] wr_addr,
	input  wire  [INSN_W-1:0]      wr_data,
	input  wire  [CODE_ADDR_W-1:0] rd_addr,
	output logic [INSN_W-1:0]      rd_data
);

	logic [INSN_W-1:0] mem [2**CODE_ADDR_W]; // maps onto block ram

	// read before write on a shared address
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];              // one cycle read latency
	end

endmodule

`default_nettype wire

// ==== src/packet_buffer.sv ====
`default_nettype none
`timescale 1ns/10ps

module packet_buffer
	import bpf_pkg::*;
(
	input  wire                   clk,
	input  wire                   wr_en,
	input  wire  [PKT_ADDR_W-1:0] wr_addr,
	input  wire  [7:0]            wr_data,
	input  wire  [PKT_ADDR_W-1:0] rd_addr,
	input  wire                   rd_half,   // halfword read, else byte
	input  wire  [PKT_ADDR_W:0]   pkt_len,
	output logic [15:0]           rd_data,
	output logic                  rd_oob
);

	logic [7:0]            mem [PKT_DEPTH];
	logic [PKT_ADDR_W-1:0] rd_addr_nx;       // second byte of a halfword
	logic [PKT_ADDR_W:0]   rd_last;          // index of last byte touched

	assign rd_addr_nx = rd_addr + 1'b1;      // wraps at the top, caught by rd_oob
	assign rd_last    = {1'b0, rd_addr} + rd_half;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// data and range flag leave together, one cycle after the address
	always_ff @(posedge clk) begin
		if (rd_half) begin
			rd_data <= {mem[rd_addr], mem[rd_addr_nx]}; // network order
		end else begin
			rd_data <= {8'h00, mem[rd_addr]};
		end
		rd_oob <= (rd_last >= pkt_len);
	end

endmodule

`default_nettype wire

// ==== src/packet_ingress.sv ====
`default_nettype none
`timescale 1ns/10ps

module packet_ingress
	import bpf_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   pkt_valid,
	input  wire  [7:0]            pkt_data,
	input  wire                   pkt_last,
	input  wire                   pkt_done,    // verdict issued, buffer free
	output logic                  pkt_credit,
	output logic                  wr_en,
	output logic [PKT_ADDR_W-1:0] wr_addr,
	output logic [7:0]            wr_data,
	output logic                  pkt_ready,
	output logic [PKT_ADDR_W:0]   pkt_len
);

	logic [PKT_ADDR_W:0] byte_cnt;             // write pointer of the frame in flight
	logic [PKT_ADDR_W:0] cnt_nx;
	logic                buf_full;
	logic                credit_due;           // first credit after reset

	assign buf_full = (byte_cnt == PKT_DEPTH); // extra bytes fall on the floor
	assign cnt_nx   = buf_full ? byte_cnt : byte_cnt + 1'b1;

	assign wr_en   = pkt_valid & ~buf_full;    // written in the cycle presented
	assign wr_addr = byte_cnt[PKT_ADDR_W-1:0];
	assign wr_data = pkt_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt   <= '0;
			pkt_ready  <= 1'b0;
			pkt_credit <= 1'b0;
			credit_due <= 1'b1;
		end else begin
			pkt_credit <= credit_due | pkt_done; // one credit = one buffer
			credit_due <= 1'b0;
			if (pkt_valid) begin
				if (pkt_last) begin
					byte_cnt  <= '0;     // restart for the next frame
					pkt_ready <= 1'b1;
				end else begin
					byte_cnt <= cnt_nx;
				end
			end
			if (pkt_done) begin
				pkt_ready <= 1'b0;
			end
		end
	end

	// length of the held frame, stable while pkt_ready
	always_ff @(posedge clk) begin
		if (pkt_valid && pkt_last) begin
			pkt_len <= cnt_nx;
		end
	end

endmodule

`default_nettype wire

// ==== src/filter_core.sv ====
`default_nettype none
`timescale 1ns/10ps

module filter_core
	import bpf_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    pkt_ready,
	output logic [CODE_ADDR_W-1:0] insn_addr,
	input  wire  [INSN_W-1:0]      insn,
	output logic [PKT_ADDR_W-1:0]  rd_addr,
	output logic                   rd_half,
	input  wire  [15:0]            rd_data,
	input  wire                    rd_oob,
	output logic                   pkt_done,
	output logic                   verdict_valid,
	output logic [31:0]            verdict
);

	logic [ST_W-1:0]        state;
	logic [CODE_ADDR_W-1:0] pc;
	logic [31:0]            a_reg;            // accumulator
	logic [31:0]            x_reg;            // index register
	bpf_opcode_t            op;               // latched instruction fields
	logic [OFF_W-1:0]       jt;
	logic [OFF_W-1:0]       jf;
	logic [K_W-1:0]         k;

	logic [31:0]            ld_addr;
	logic                   ld_legal;
	logic                   jmp_legal;
	logic                   jmp_take;
	logic [CODE_ADDR_W:0]   jmp_off;
	logic [CODE_ADDR_W:0]   pc_inc;           // msb set means ran off the end
	logic [CODE_ADDR_W:0]   pc_jmp;
	logic                   halt;             // program ends this cycle
	logic [31:0]            halt_val;

	assign insn_addr = pc;                    // code ram answers in WAIT
	assign pkt_done  = verdict_valid;

	// packet read port follows the latched load
	assign ld_addr = (op.ld.mode == MODE_IND) ? x_reg + k : k;
	assign rd_addr = ld_addr[PKT_ADDR_W-1:0];
	assign rd_half = (op.ld.size == SIZE_H);

	// ldx only knows msh byte loads
	assign ld_legal = (op.ld.cls == CLS_LDX) ?
		(op.ld.mode == MODE_MSH && op.ld.size == SIZE_B) :
		((op.ld.mode == MODE_ABS || op.ld.mode == MODE_IND) &&
		 (op.ld.size == SIZE_H || op.ld.size == SIZE_B));

	assign jmp_legal = (op.jmp.op == JOP_JEQ || op.jmp.op == JOP_JSET) && (op.jmp.src == SRC_K);
	assign jmp_take  = (op.jmp.op == JOP_JSET) ? |(a_reg & k) : (a_reg == k);
	assign jmp_off   = {{(CODE_ADDR_W+1-OFF_W){1'b0}}, jmp_take ? jt : jf};
	assign pc_inc    = {1'b0, pc} + 1'b1;
	assign pc_jmp    = pc_inc + jmp_off;      // pc + 1 + jt/jf

	// every way out of the program, with its return value
	always_comb begin
		halt     = 1'b0;
		halt_val = '0;
		if (state == ST_EXEC) begin
			case (op.ld.cls)
				CLS_LD, CLS_LDX: halt = !ld_legal || (|ld_addr[31:PKT_ADDR_W]);
				CLS_JMP:         halt = !jmp_legal || pc_jmp[CODE_ADDR_W];
				CLS_RET: begin
					halt     = 1'b1;
					halt_val = (op.jmp.src == SRC_A) ? a_reg : k;
				end
				default:         halt = 1'b1; // unsupported class, drop
			endcase
		end else if (state == ST_LOAD) begin
			halt = rd_oob || pc_inc[CODE_ADDR_W]; // short frame drops like bpf
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= ST_IDLE;
			verdict_valid <= 1'b0;
		end else begin
			verdict_valid <= 1'b0;
			if (halt) begin
				verdict       <= halt_val;
				verdict_valid <= 1'b1;
				state         <= ST_IDLE;
			end else begin
				case (state)
					ST_IDLE: begin
						// ready drops a cycle after done, skip that cycle
						if (pkt_ready && !verdict_valid) begin
							pc    <= '0;
							a_reg <= '0;
							x_reg <= '0;
							state <= ST_FETCH;
						end
					end
					ST_FETCH: state <= ST_WAIT;
					ST_WAIT: begin
						op    <= insn[OPC_LSB +: OPC_W];
						jt    <= insn[JT_LSB +: OFF_W];
						jf    <= insn[JF_LSB +: OFF_W];
						k     <= insn[K_W-1:0];
						state <= ST_EXEC;
					end
					ST_EXEC: begin
						if (op.jmp.cls == CLS_JMP) begin
							pc    <= pc_jmp[CODE_ADDR_W-1:0];
							state <= ST_FETCH;
						end else begin
							state <= ST_LOAD; // buffer read in flight
						end
					end
					ST_LOAD: begin
						if (op.ld.cls == CLS_LDX) begin
							x_reg <= {26'b0, rd_data[3:0], 2'b00}; // ip header length
						end else begin
							a_reg <= {16'b0, rd_data};
						end
						pc    <= pc_inc[CODE_ADDR_W-1:0];
						state <= ST_FETCH;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/packet_filter_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module packet_filter_top
	import bpf_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    prog_wr_en,
	input  wire  [CODE_ADDR_W-1:0] prog_addr,
	input  wire  [INSN_W-1:0]      prog_data,
	output logic                   pkt_credit,
	input  wire                    pkt_valid,
	input  wire  [7:0]             pkt_data,
	input  wire                    pkt_last,
	output logic                   verdict_valid,
	output logic [31:0]            verdict
);

	logic                   wr_en;
	logic [PKT_ADDR_W-1:0]  wr_addr;
	logic [7:0]             wr_data;
	logic                   pkt_ready;
	logic [PKT_ADDR_W:0]    pkt_len;
	logic                   pkt_done;
	logic [PKT_ADDR_W-1:0]  rd_addr;
	logic                   rd_half;
	logic [15:0]            rd_data;
	logic                   rd_oob;
	logic [CODE_ADDR_W-1:0] insn_addr;
	logic [INSN_W-1:0]      insn;

	code_ram u_code_ram (
		.clk(clk), .wr_en(prog_wr_en), .wr_addr(prog_addr), .wr_data(prog_data),
		.rd_addr(insn_addr), .rd_data(insn)
	);

	packet_buffer u_packet_buffer (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_half(rd_half), .pkt_len(pkt_len),
		.rd_data(rd_data), .rd_oob(rd_oob)
	);

	packet_ingress u_packet_ingress (
		.clk(clk), .rst(rst), .pkt_valid(pkt_valid), .pkt_data(pkt_data),
		.pkt_last(pkt_last), .pkt_done(pkt_done), .pkt_credit(pkt_credit),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.pkt_ready(pkt_ready), .pkt_len(pkt_len)
	);

	filter_core u_filter_core (
		.clk(clk), .rst(rst), .pkt_ready(pkt_ready), .insn_addr(insn_addr), .insn(insn),
		.rd_addr(rd_addr), .rd_half(rd_half), .rd_data(rd_data), .rd_oob(rd_oob),
		.pkt_done(pkt_done), .verdict_valid(verdict_valid), .verdict(verdict)
	);

endmodule

`default_nettype wire

// ==== testbench/packet_filter_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module packet_filter_tb
	import bpf_pkg::*;
;

	localparam int NUM_CASES  = 8;
	localparam int WAIT_LIMIT = 2000;          // cycles per wait

	typedef struct packed {
		logic [15:0] ethertype;
		logic [7:0]  proto;
		logic [15:0] frag;                     // flags and fragment offset
		logic [15:0] sport;
		logic [15:0] dport;
		logic [15:0] len;                      // frame length in bytes
		logic [31:0] verdict;                  // expected return value
	} pkt_case_t;

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   prog_wr_en;
	logic [CODE_ADDR_W-1:0] prog_addr;
	logic [INSN_W-1:0]      prog_data;
	logic                   pkt_credit;
	logic                   pkt_valid;
	logic [7:0]             pkt_data;
	logic                   pkt_last;
	logic                   verdict_valid;
	logic [31:0]            verdict;

	pkt_case_t cases [NUM_CASES];
	pkt_case_t c;
	integer    seed;
	int        errors       = 0;
	int        timeouts     = 0;           // waits that ran out
	int        packets      = 0;           // frames sent so far
	int        credit_cnt   = 0;           // credit pulses seen, reset included
	int        verdict_cnt  = 0;
	logic [31:0] last_verdict = '0;

	packet_filter_top DUT (
		.clk(clk), .rst(rst),
		.prog_wr_en(prog_wr_en), .prog_addr(prog_addr), .prog_data(prog_data),
		.pkt_credit(pkt_credit), .pkt_valid(pkt_valid), .pkt_data(pkt_data),
		.pkt_last(pkt_last), .verdict_valid(verdict_valid), .verdict(verdict)
	);

	always #10 clk = ~clk;                     // 20 ns period

	// pulses counted away from the edge
	always @(negedge clk) begin
		if (pkt_credit) credit_cnt++;
		if (verdict_valid) begin
			verdict_cnt++;
			last_verdict = verdict;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, actual, expected,
				$time);
			errors++;
		end
	endtask

	// opcode words built through the shared union
	function automatic logic [INSN_W-1:0] load_insn(input logic [2:0] cls,
			input logic [2:0] mode, input logic [1:0] size, input logic [31:0] k);
		bpf_opcode_t op;
		op         = '0;
		op.ld.cls  = cls;
		op.ld.mode = mode;
		op.ld.size = size;
		return {op, 8'h00, 8'h00, k};
	endfunction

	function automatic logic [INSN_W-1:0] jump_insn(input logic [3:0] jop,
			input logic [7:0] jt, input logic [7:0] jf, input logic [31:0] k);
		bpf_opcode_t op;
		op         = '0;
		op.jmp.cls = CLS_JMP;
		op.jmp.op  = jop;
		op.jmp.src = SRC_K;
		return {op, jt, jf, k};
	endfunction

	function automatic logic [INSN_W-1:0] ret_insn(input logic src, input logic [31:0] k);
		bpf_opcode_t op;
		op         = '0;
		op.jmp.cls = CLS_RET;
		op.jmp.src = src;
		return {op, 8'h00, 8'h00, k};
	endfunction

	task automatic write_code(input int addr, input logic [INSN_W-1:0] word);
		@(posedge clk);
		prog_wr_en <= 1'b1;
		prog_addr  <= addr[CODE_ADDR_W-1:0];
		prog_data  <= word;
		@(posedge clk);
		prog_wr_en <= 1'b0;
	endtask

	// accepts ipv4 tcp frames between ports 100 and 200 in either direction
	task automatic load_program();
		write_code(0,  load_insn(CLS_LD, MODE_ABS, SIZE_H, 32'd12));      // ethertype
		write_code(1,  jump_insn(JOP_JEQ, 8'd0, 8'd13, 32'h0800));
		write_code(2,  load_insn(CLS_LD, MODE_ABS, SIZE_B, 32'd23));      // ip protocol
		write_code(3,  jump_insn(JOP_JEQ, 8'd0, 8'd11, 32'd6));
		write_code(4,  load_insn(CLS_LD, MODE_ABS, SIZE_H, 32'd20));      // frag field
		write_code(5,  jump_insn(JOP_JSET, 8'd9, 8'd0, 32'h1fff));
		write_code(6,  load_insn(CLS_LDX, MODE_MSH, SIZE_B, 32'd14));     // x = ip hdr len
		write_code(7,  load_insn(CLS_LD, MODE_IND, SIZE_H, 32'd14));      // source port
		write_code(8,  jump_insn(JOP_JEQ, 8'd0, 8'd2, 32'd100));
		write_code(9,  load_insn(CLS_LD, MODE_IND, SIZE_H, 32'd16));      // dest port
		write_code(10, jump_insn(JOP_JEQ, 8'd3, 8'd4, 32'd200));
		write_code(11, jump_insn(JOP_JEQ, 8'd0, 8'd3, 32'd200));
		write_code(12, load_insn(CLS_LD, MODE_IND, SIZE_H, 32'd16));
		write_code(13, jump_insn(JOP_JEQ, 8'd0, 8'd1, 32'd100));
		write_code(14, ret_insn(SRC_K, 32'd65535));                       // accept
		write_code(15, ret_insn(SRC_K, 32'd0));                           // drop
	endtask

	task automatic wait_credit(input int target);
		int n;
		n = 0;
		while (credit_cnt < target && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (credit_cnt < target) begin
			$display("Timeout: no pkt_credit arrived within %0d cycles at %0t", WAIT_LIMIT,
				$time);
			timeouts++;
		end
	endtask

	task automatic wait_verdict(input int target);
		int n;
		n = 0;
		while (verdict_cnt < target && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (verdict_cnt < target) begin
			$display("Timeout: no verdict_valid arrived within %0d cycles at %0t", WAIT_LIMIT,
				$time);
			timeouts++;
		end
	endtask

	task automatic send_frame(input pkt_case_t p);
		logic [7:0]  frame [PKT_DEPTH];
		logic [31:0] rnd;
		int          i;
		for (i = 0; i < PKT_DEPTH; i++) begin
			rnd      = $random(seed);
			frame[i] = rnd[7:0];               // filler for fields not under test
		end
		frame[12] = p.ethertype[15:8];
		frame[13] = p.ethertype[7:0];
		frame[14] = 8'h45;                     // ipv4 with 20 byte header
		frame[20] = p.frag[15:8];
		frame[21] = p.frag[7:0];
		frame[23] = p.proto;
		frame[34] = p.sport[15:8];             // tcp header right after ip
		frame[35] = p.sport[7:0];
		frame[36] = p.dport[15:8];
		frame[37] = p.dport[7:0];
		for (i = 0; i < p.len; i++) begin
			@(posedge clk);
			pkt_valid <= 1'b1;
			pkt_data  <= frame[i];
			pkt_last  <= (i == p.len - 1);
		end
		@(posedge clk);
		pkt_valid <= 1'b0;
		pkt_last  <= 1'b0;
	endtask

	// one frame through the filter and exactly one fresh credit after it
	task automatic run_packet(input pkt_case_t p);
		send_frame(p);
		packets++;
		wait_verdict(packets);
		if (timeouts == 0) begin
			check_value("verdict", last_verdict, p.verdict);
			check_value("verdict_valid count", verdict_cnt, packets);
			wait_credit(packets + 1);
		end
		if (timeouts == 0) begin
			repeat (4) @(posedge clk);
			check_value("pkt_credit count", credit_cnt, packets + 1);
		end
	endtask

	task automatic fill_table();
		//           ethertype  proto  frag      sport    dport    len     verdict
		cases[0] = {16'h0800, 8'd6,  16'h0000, 16'd100, 16'd200, 16'd60, 32'd65535};
		cases[1] = {16'h0800, 8'd6,  16'h0000, 16'd200, 16'd100, 16'd60, 32'd65535};
		cases[2] = {16'h0800, 8'd6,  16'h0000, 16'd100, 16'd100, 16'd60, 32'd0};
		cases[3] = {16'h0800, 8'd6,  16'h0000, 16'd300, 16'd400, 16'd60, 32'd0};
		cases[4] = {16'h86dd, 8'd6,  16'h0000, 16'd100, 16'd200, 16'd60, 32'd0}; // ipv6
		cases[5] = {16'h0800, 8'd17, 16'h0000, 16'd100, 16'd200, 16'd60, 32'd0}; // udp
		cases[6] = {16'h0800, 8'd6,  16'h0010, 16'd100, 16'd200, 16'd60, 32'd0}; // frag
		cases[7] = {16'h0800, 8'd6,  16'h0000, 16'd100, 16'd200, 16'd36, 32'd0}; // short
	endtask

	initial begin
		seed       = 32'h0d3bef6e;
		rst        = 1'b1;
		prog_wr_en = 1'b0;
		prog_addr  = '0;
		prog_data  = '0;
		pkt_valid  = 1'b0;
		pkt_data   = '0;
		pkt_last   = 1'b0;
		fill_table();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		load_program();                        // buffer still empty here
		wait_credit(1);
		if (timeouts == 0) begin
			repeat (4) @(posedge clk);
			check_value("pkt_credit count", credit_cnt, 1); // single credit after reset
			check_value("verdict_valid count", verdict_cnt, 0);
		end
		for (int i = 0; i < NUM_CASES && timeouts == 0; i++) begin
			run_packet(cases[i]);
		end
		if (timeouts == 0) begin
			write_code(14, ret_insn(SRC_A, 32'd0)); // accept now returns the last dest port
			c         = cases[0];
			c.verdict = 32'd200;
			run_packet(c);
		end
		if (timeouts == 0) begin
			write_code(0, load_insn(3'h4, 3'h0, 2'h0, 32'd0)); // alu class is not supported
			c.verdict = 32'd0;
			run_packet(c);
		end
		$display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
src/bpf_pkg.sv
src/code_ram.sv
src/packet_buffer.sv
src/packet_ingress.sv
src/filter_core.sv
src/packet_filter_top.sv
testbench/packet_filter_tb.sv

// ==== Bender.yml ====
package:
  name: packet_filter

sources:
  - src/bpf_pkg.sv
  - src/code_ram.sv
  - src/packet_buffer.sv
  - src/packet_ingress.sv
  - src/filter_core.sv
  - src/packet_filter_top.sv
  - target: test
    files:
      - testbench/packet_filter_tb.sv
